// File: build.f
fir_types_pkg.sv
fir_ctrl_pkg.sv
tap_if.sv
fir_sequencer.sv
fill_counter.sv
tap_store.sv
quad_mac.sv
dot8_pipe.sv
fir8_top.sv
tb_clock.sv
fir8_tb.sv

// File: fir8_tb.sv
`timescale 1ns/1ps

module fir8_tb
	import fir_types_pkg::*;
	import fir_ctrl_pkg::*;
();

	localparam int drain_limit = 40;

	logic clk;
	logic areset;
	logic sample_valid;
	sample_t sample;
	logic coef_we;
	tap_addr_t coef_addr;
	coef_t coef_data;
	logic clear;
	logic result_valid;
	result_t result;
	logic busy;

	sample_t m_line [taps]; // model delay line, newest first.
	coef_t m_coef [taps];
	int m_count;
	seq_state_t m_state;
	int exp_val [$];
	int exp_due [$];
	int got [$]; // results seen since the test began.
	int cyc;
	int errors;
	int checks;
	int tests;
	int test_start_errors;
	int accepted;

	tb_clock clk0 (.clk (clk));

	fir8_top dut0 (
		.clk (clk),
		.areset (areset),
		.sample_valid (sample_valid),
		.sample (sample),
		.coef_we (coef_we),
		.coef_addr (coef_addr),
		.coef_data (coef_data),
		.clear (clear),
		.result_valid (result_valid),
		.result (result),
		.busy (busy)
	);

	// outputs are sampled at the falling edge.
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (result_valid) begin
			got.push_back(int'(result));
			checks++;
			if (exp_val.size() == 0) begin
				errors++;
				$display("unexpected result %0d at %0t with nothing pending", result, $time);
			end else begin
				if (int'(result) != exp_val[0]) begin
					errors++;
					$display("MISMATCH at %0t: result expected %0d got %0d",
						$time, exp_val[0], result);
				end
				if (cyc != exp_due[0]) begin
					errors++;
					$display("MISMATCH at %0t: result due in cycle %0d came in cycle %0d",
						$time, exp_due[0], cyc);
				end
				void'(exp_val.pop_front());
				void'(exp_due.pop_front());
			end
		end else if (exp_due.size() != 0 && exp_due[0] <= cyc) begin
			errors++;
			$display("result due in cycle %0d did not arrive (time %0t)", exp_due[0], $time);
			void'(exp_val.pop_front());
			void'(exp_due.pop_front());
		end
	end

	task automatic check_value(input string what, input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("MISMATCH at %0t: %s expected %0d got %0d", $time, what, expected, actual);
		end
	endtask

	// one clock of stimulus, mirrored into the model.
	task automatic step(input logic sv, input sample_t smp, input logic we,
		input tap_addr_t addr, input coef_t data, input logic clr);
		int acc;
		logic tag;
		@(posedge clk);
		sample_valid <= sv;
		sample <= smp;
		coef_we <= we;
		coef_addr <= addr;
		coef_data <= data;
		clear <= clr;
		if (we && !sv && m_state == st_idle) begin
			m_coef[addr] = data;
		end
		if (clr) begin
			for (int k = 0; k < taps; k++) begin
				m_line[k] = '0;
			end
			m_count = 0;
			m_state = st_idle;
		end else if (sv) begin
			tag = (m_count == taps - 1) || (m_state == st_stream);
			for (int k = taps - 1; k > 0; k--) begin
				m_line[k] = m_line[k-1];
			end
			m_line[0] = smp;
			if (m_state == st_idle) begin
				m_state = st_fill;
			end else if (m_state == st_fill && m_count == taps - 1) begin
				m_state = st_stream;
			end
			if (m_count < taps - 1) begin
				m_count++;
			end
			accepted++;
			if (tag) begin
				acc = 0;
				for (int k = 0; k < taps; k++) begin
					acc += int'(m_line[k]) * int'(m_coef[k]);
				end
				exp_val.push_back(acc);
				exp_due.push_back(cyc + pipe_latency + 1); // strobe is seen at the next edge.
			end
		end
	endtask

	task automatic idle(input int n);
		for (int i = 0; i < n; i++) begin
			step(1'b0, '0, 1'b0, '0, '0, 1'b0);
		end
	endtask

	task automatic send(input sample_t smp);
		step(1'b1, smp, 1'b0, '0, '0, 1'b0);
	endtask

	function automatic sample_t rand_sample();
		return sample_t'(int'($urandom_range(511, 0)) - 256);
	endfunction

	function automatic int rand_extreme();
		return ($urandom_range(1, 0) == 1) ? 255 : -256;
	endfunction

	task automatic restart_with_random_coefs();
		step(1'b0, '0, 1'b0, '0, '0, 1'b1);
		for (int k = 0; k < taps; k++) begin
			step(1'b0, '0, 1'b1, tap_addr_t'(k), coef_t'(rand_sample()), 1'b0);
		end
	endtask

	task automatic wait_results(input string what);
		int waited;
		waited = 0;
		while (exp_val.size() != 0 && waited < drain_limit) begin
			idle(1);
			waited++;
		end
		if (exp_val.size() != 0) begin
			errors++;
			$display("timed out waiting for %s results, %0d never arrived", what, exp_val.size());
			exp_val.delete();
			exp_due.delete();
		end
		idle(pipe_latency + 1); // room for a stray result to show up.
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %0d %s done, %0d errors", tests, name, errors - test_start_errors);
		test_start_errors = errors;
		got.delete();
	endtask

	initial begin
		int start;
		void'($urandom(32'h9aec_d031));
		areset = 1'b1;
		sample_valid = 1'b0;
		sample = '0;
		coef_we = 1'b0;
		coef_addr = '0;
		coef_data = '0;
		clear = 1'b0;
		cyc = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		test_start_errors = 0;
		accepted = 0;
		m_count = 0;
		m_state = st_idle;
		for (int k = 0; k < taps; k++) begin
			m_line[k] = '0;
			m_coef[k] = '0;
		end
		repeat (8) @(posedge clk);
		areset <= 1'b0;
		@(negedge clk);

		check_value("result_valid after reset", 0, result_valid);
		check_value("busy after reset", 0, busy);
		check_value("result after reset", 0, result);
		for (int i = 0; i < taps; i++) begin
			send(rand_sample());
		end
		wait_results("reset");
		check_value("results from eight samples", 1, got.size());
		finish_test("reset state");

		restart_with_random_coefs();
		idle(1);
		for (int i = 0; i < 2 * taps - 1; i++) begin
			send((i == taps - 1) ? sample_t'(1) : sample_t'(0)); // impulse sits at the eighth.
		end
		wait_results("impulse");
		check_value("impulse result count", taps, got.size());
		for (int k = 0; k < taps && k < got.size(); k++) begin
			check_value("impulse response tap", int'(m_coef[k]), got[k]);
		end
		finish_test("impulse response");

		restart_with_random_coefs();
		start = accepted;
		for (int i = 0; i < 300; i++) begin
			if ($urandom_range(99, 0) < 60) begin
				send(rand_sample());
			end else begin
				idle(1);
			end
		end
		wait_results("streaming");
		check_value("streaming result count", accepted - start - (taps - 1), got.size());
		finish_test("streaming");

		step(1'b0, '0, 1'b0, '0, '0, 1'b1);
		for (int k = 0; k < taps; k++) begin
			step(1'b0, '0, 1'b1, tap_addr_t'(k), coef_t'(-256), 1'b0);
		end
		for (int i = 0; i < 12; i++) begin
			send(sample_t'(-256));
		end
		wait_results("full scale");
		if (got.size() == 0) begin
			errors++;
			$display("no full scale result was produced");
		end else begin
			check_value("full scale sum", taps * 256 * 256, got[0]);
		end
		step(1'b0, '0, 1'b0, '0, '0, 1'b1);
		for (int k = 0; k < taps; k++) begin
			step(1'b0, '0, 1'b1, tap_addr_t'(k), coef_t'(rand_extreme()), 1'b0);
		end
		for (int i = 0; i < 40; i++) begin
			send(sample_t'(rand_extreme()));
		end
		wait_results("mixed extreme");
		finish_test("extreme values");

		restart_with_random_coefs();
		for (int i = 0; i < 10; i++) begin
			send(rand_sample());
		end
		for (int k = 0; k < taps; k++) begin
			step(1'b0, '0, 1'b1, tap_addr_t'(k), coef_t'(rand_sample()), 1'b0);
			step(1'b1, rand_sample(), 1'b1, tap_addr_t'(k), coef_t'(rand_sample()), 1'b0);
		end
		@(negedge clk);
		check_value("busy during ignored writes", 1, busy);
		for (int i = 0; i < 10; i++) begin
			send(rand_sample());
		end
		wait_results("ignored write");
		finish_test("ignored coefficient writes");

		restart_with_random_coefs();
		for (int i = 0; i < 12; i++) begin
			send(rand_sample());
		end
		step(1'b1, rand_sample(), 1'b0, '0, '0, 1'b1); // sample is dropped.
		idle(1);
		@(negedge clk);
		check_value("busy after clear", 0, busy);
		wait_results("pre-clear");
		got.delete();
		for (int i = 0; i < taps - 1; i++) begin
			send(rand_sample());
		end
		wait_results("post-clear fill");
		check_value("results from seven samples", 0, got.size());
		send(rand_sample());
		wait_results("post-clear window");
		check_value("results from the eighth sample", 1, got.size());
		finish_test("clear");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	localparam time half_period = 50ns; // 100 ns period.

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

endmodule

// File: fir8_top.sv
`timescale 1ns/1ps

module fir8_top
	import fir_types_pkg::*;
	import fir_ctrl_pkg::*;
(
	input logic clk,
	input logic areset,
	input logic sample_valid,
	input sample_t sample,
	input logic coef_we,
	input tap_addr_t coef_addr,
	input coef_t coef_data,
	input logic clear,
	output logic result_valid,
	output result_t result,
	output logic busy
);

	logic shift;
	logic flush;
	logic coef_load;
	logic sample_tag;
	logic line_full_next;

	tap_if tap_bus ();

	fir_sequencer seq0 (
		.clk (clk),
		.areset (areset),
		.sample_valid (sample_valid),
		.clear (clear),
		.coef_we (coef_we),
		.line_full_next (line_full_next),
		.shift (shift),
		.flush (flush),
		.coef_load (coef_load),
		.sample_tag (sample_tag),
		.busy (busy)
	);

	fill_counter cnt0 (
		.clk (clk),
		.areset (areset),
		.shift (shift),
		.flush (flush),
		.line_full_next (line_full_next)
	);

	tap_store store0 (
		.clk (clk),
		.areset (areset),
		.shift (shift),
		.flush (flush),
		.coef_load (coef_load),
		.sample_tag (sample_tag),
		.sample (sample),
		.coef_addr (coef_addr),
		.coef_data (coef_data),
		.st (tap_bus.store)
	);

	dot8_pipe pipe0 (
		.clk (clk),
		.areset (areset),
		.mac (tap_bus.mac),
		.result (result),
		.result_valid (result_valid)
	);

endmodule

// File: dot8_pipe.sv
`timescale 1ns/1ps

module dot8_pipe import fir_types_pkg::*; (
	input logic clk,
	input logic areset,
	tap_if.mac mac,
	output result_t result,
	output logic result_valid
);

	quad_sum_t sum_lo;
	quad_sum_t sum_hi;
	logic [3:0] tag_q;

	quad_mac mac_lo (
		.clk (clk),
		.areset (areset),
		.a0 (mac.taps[0]),
		.a1 (mac.taps[1]),
		.a2 (mac.taps[2]),
		.a3 (mac.taps[3]),
		.b0 (mac.coefs[0]),
		.b1 (mac.coefs[1]),
		.b2 (mac.coefs[2]),
		.b3 (mac.coefs[3]),
		.sum (sum_lo)
	);

	quad_mac mac_hi (
		.clk (clk),
		.areset (areset),
		.a0 (mac.taps[4]),
		.a1 (mac.taps[5]),
		.a2 (mac.taps[6]),
		.a3 (mac.taps[7]),
		.b0 (mac.coefs[4]),
		.b1 (mac.coefs[5]),
		.b2 (mac.coefs[6]),
		.b3 (mac.coefs[7]),
		.sum (sum_hi)
	);

	always_ff @(posedge clk or posedge areset) begin
		if (areset) begin
			result <= '0;
			tag_q <= '0;
		end else begin
			result <= sum_lo + sum_hi;
			tag_q <= {tag_q[2:0], mac.tag}; // follows the three mac stages and the sum.
		end
	end

	assign result_valid = tag_q[3];

endmodule

// File: quad_mac.sv
`timescale 1ns/1ps

module quad_mac import fir_types_pkg::*; (
	input logic clk,
	input logic areset,
	input sample_t a0,
	input sample_t a1,
	input sample_t a2,
	input sample_t a3,
	input coef_t b0,
	input coef_t b1,
	input coef_t b2,
	input coef_t b3,
	output quad_sum_t sum
);

	sample_t a0_q, a1_q, a2_q, a3_q;
	coef_t b0_q, b1_q, b2_q, b3_q;
	pair_sum_t p0;
	pair_sum_t p1;

	always_ff @(posedge clk or posedge areset) begin
		if (areset) begin
			a0_q <= '0;
			a1_q <= '0;
			a2_q <= '0;
			a3_q <= '0;
			b0_q <= '0;
			b1_q <= '0;
			b2_q <= '0;
			b3_q <= '0;
			p0 <= '0;
			p1 <= '0;
			sum <= '0;
		end else begin
			a0_q <= a0; // stage 1.
			a1_q <= a1;
			a2_q <= a2;
			a3_q <= a3;
			b0_q <= b0;
			b1_q <= b1;
			b2_q <= b2;
			b3_q <= b3;
			p0 <= a0_q * b0_q + a1_q * b1_q; // stage 2.
			p1 <= a2_q * b2_q + a3_q * b3_q;
			sum <= p0 + p1; // stage 3.
		end
	end

endmodule

// File: tap_store.sv
`timescale 1ns/1ps

module tap_store
	import fir_types_pkg::*;
	import fir_ctrl_pkg::*;
(
	input logic clk,
	input logic areset,
	input logic shift,
	input logic flush,
	input logic coef_load,
	input logic sample_tag,
	input sample_t sample,
	input tap_addr_t coef_addr,
	input coef_t coef_data,
	tap_if.store st
);

	// delay line.
	always_ff @(posedge clk or posedge areset) begin
		if (areset) begin
			for (int i = 0; i < taps; i++) begin
				st.taps[i] <= '0;
			end
		end else if (flush) begin
			for (int i = 0; i < taps; i++) begin
				st.taps[i] <= '0;
			end
		end else if (shift) begin
			st.taps[0] <= sample;
			for (int i = 1; i < taps; i++) begin
				st.taps[i] <= st.taps[i-1];
			end
		end
	end

	// coefficient bank survives a clear.
	always_ff @(posedge clk or posedge areset) begin
		if (areset) begin
			for (int i = 0; i < taps; i++) begin
				st.coefs[i] <= '0;
			end
		end else if (coef_load) begin
			st.coefs[coef_addr] <= coef_data;
		end
	end

	always_ff @(posedge clk or posedge areset) begin
		if (areset) begin
			st.tag <= 1'b0;
		end else begin
			st.tag <= sample_tag; // same edge as the shift.
		end
	end

endmodule

// File: fill_counter.sv
`timescale 1ns/1ps

module fill_counter import fir_ctrl_pkg::*; (
	input logic clk,
	input logic areset,
	input logic shift,
	input logic flush,
	output logic line_full_next
);

	localparam tap_addr_t max_count = tap_addr_t'(taps - 1);

	tap_addr_t count;

	assign line_full_next = (count == max_count); // next shift fills the line.

	always_ff @(posedge clk or posedge areset) begin
		if (areset) begin
			count <= '0;
		end else if (flush) begin
			count <= '0;
		end else if (shift && count != max_count) begin
			count <= count + 1'b1;
		end
	end

	// once full, the counter stays full until a clear.
	a_no_wrap: assert property (@(posedge clk) disable iff (areset)
		(count == max_count && !flush) |=> count == max_count);

endmodule

// File: fir_sequencer.sv
`timescale 1ns/1ps

module fir_sequencer import fir_ctrl_pkg::*; (
	input logic clk,
	input logic areset,
	input logic sample_valid,
	input logic clear,
	input logic coef_we,
	input logic line_full_next,
	output logic shift,
	output logic flush,
	output logic coef_load,
	output logic sample_tag,
	output logic busy
);

	seq_state_t state;
	seq_state_t state_next;

	assign flush = clear;
	assign shift = sample_valid && !clear; // clear wins.
	assign coef_load = coef_we && !sample_valid && (state == st_idle);

	// this sample closes a full window.
	assign sample_tag = shift && (line_full_next || state == st_stream);

	assign busy = (state != st_idle);

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (shift) state_next = st_fill;
			end
			st_fill: begin
				if (shift && line_full_next) state_next = st_stream;
			end
			st_stream: begin
				state_next = st_stream;
			end
			default: begin
				state_next = st_idle;
			end
		endcase
		if (flush) state_next = st_idle;
	end

	always_ff @(posedge clk or posedge areset) begin
		if (areset) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	// fill count and state agree, no full line while idle.
	a_full_not_idle: assert property (@(posedge clk) disable iff (areset)
		line_full_next |-> busy);

	// a tagged sample leaves the filter streaming.
	a_tag_streams: assert property (@(posedge clk) disable iff (areset)
		sample_tag |=> state == st_stream);

endmodule

// File: tap_if.sv
`timescale 1ns/1ps

interface tap_if import fir_types_pkg::*; ();

	sample_t taps [8]; // taps[0] is the newest sample.
	coef_t coefs [8];
	logic tag; // window behind these taps is valid.

	modport store (
		output taps,
		output coefs,
		output tag
	);

	modport mac (
		input taps,
		input coefs,
		input tag
	);

endinterface

// File: fir_ctrl_pkg.sv
package fir_ctrl_pkg;

	localparam int taps = 8;

	// sample strobe to result_valid, in cycles.
	localparam int pipe_latency = 5;

	typedef logic [$clog2(taps)-1:0] tap_addr_t;

	typedef enum logic [1:0] {
		st_idle,
		st_fill,
		st_stream
	} seq_state_t;

endpackage

// File: fir_types_pkg.sv
package fir_types_pkg;

	localparam int sample_w = 9;
	localparam int coef_w = 9;

	// full product width of one sample times one coefficient.
	localparam int prod_w = sample_w + coef_w;

	localparam int pair_w = prod_w + 1;
	localparam int quad_w = prod_w + 2;
	localparam int result_w = prod_w + 3;

	typedef logic signed [sample_w-1:0] sample_t;

	typedef logic signed [coef_w-1:0] coef_t;

	// sum of two products.
	typedef logic signed [pair_w-1:0] pair_sum_t;

	// sum of four products, one quad_mac.
	typedef logic signed [quad_w-1:0] quad_sum_t;

	// eight products, full precision.
	typedef logic signed [result_w-1:0] result_t;

endpackage
